/* hw/host_mem_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// host memory read path shared widths and channel structs
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package host_mem_pkg;

    // addresses and lengths count whole lines
    localparam int ADDR_W = 16;
    // a length field holds the number of lines minus one
    localparam int LEN_W  = 4;
    localparam int ID_W   = 4;
    localparam int DATA_W = 32;
    // widest reorder slot index that any configuration may use
    localparam int TAG_W  = 4;

    // client read request
    typedef struct packed {
        logic [ID_W-1:0]   id;
        logic [ADDR_W-1:0] addr;
        logic [LEN_W-1:0]  len;
    } rd_req_t;

    // host read burst and the tag is the reorder slot of its first line
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [LEN_W-1:0]  len;
        logic [TAG_W-1:0]  tag;
    } host_req_t;

    // one line returned by the host, tagged with its own slot
    typedef struct packed {
        logic [TAG_W-1:0]  tag;
        logic [DATA_W-1:0] data;
    } host_rsp_t;

    // per request header kept until the last response line
    typedef struct packed {
        logic [ID_W-1:0]  id;
        logic [LEN_W-1:0] len;
    } rsp_hdr_t;

    // client response line
    typedef struct packed {
        logic [ID_W-1:0]   id;
        logic [DATA_W-1:0] data;
        logic              last;
    } rd_rsp_t;

endpackage

/* hw/burst_splitter.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// burst splitter cuts client reads into page safe host bursts
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module burst_splitter
  #(
    parameter int ROB_DEPTH       = 16,
    parameter int MAX_BURST_LINES = 4,
    parameter int PAGE_LINES      = 8
    )
   (
    input  logic                                clk,
    input  logic                                arst_n,
    input  host_mem_pkg::rd_req_t               rd_req,
    input  logic                                rd_req_valid,
    output logic                                rd_req_ready,
    output host_mem_pkg::host_req_t             host_req,
    output logic                                host_req_valid,
    input  logic                                host_req_ready,
    output host_mem_pkg::rsp_hdr_t              hdr,
    output logic                                hdr_valid,
    output logic                                alloc_valid,
    output logic [$clog2(ROB_DEPTH+1)-1:0]      alloc_lines,
    input  logic [$clog2(ROB_DEPTH+1)-1:0]      free_slots,
    input  logic [host_mem_pkg::TAG_W-1:0]      next_tag
    );

    localparam int CNT_W = $clog2(ROB_DEPTH + 1);
    localparam int PG_W  = $clog2(PAGE_LINES);
    localparam int LEN_W = host_mem_pkg::LEN_W;

    logic                             busy;
    logic                             ready_q;
    logic [host_mem_pkg::ADDR_W-1:0]  cur_addr;
    // lines still to issue, one bit wider than a length field
    logic [LEN_W:0]                   remain;
    logic [PG_W:0]                    page_left;
    logic [31:0]                      burst_lim;
    logic                             req_xfer;
    logic                             burst_xfer;

    assign rd_req_ready = ready_q;
    assign req_xfer     = rd_req_valid && rd_req_ready;
    assign burst_xfer   = host_req_valid && host_req_ready;

    // the header leaves for the packer as soon as the request is taken
    assign hdr.id    = rd_req.id;
    assign hdr.len   = rd_req.len;
    assign hdr_valid = req_xfer;

    // lines between the current address and the next page boundary
    assign page_left = (PG_W+1)'(PAGE_LINES) - {1'b0, cur_addr[PG_W-1:0]};

    always_comb
    begin
        // smallest of the burst limit, the remaining lines and the page room
        burst_lim = MAX_BURST_LINES;
        if (32'(remain) < burst_lim)
        begin
            burst_lim = 32'(remain);
        end
        if (32'(page_left) < burst_lim)
        begin
            burst_lim = 32'(page_left);
        end
    end

    always_comb
    begin
        host_req.addr = cur_addr;
        host_req.len  = burst_lim[LEN_W-1:0] - 1'b1;
        // the slot of the first line is wherever the reorder tail sits now
        host_req.tag  = next_tag;
    end

    // a burst is offered only when every one of its lines has a free slot
    // and free_slots can only grow until our own transfer, so valid holds
    assign host_req_valid = busy && (32'(free_slots) >= burst_lim);

    assign alloc_valid = burst_xfer;
    assign alloc_lines = burst_lim[CNT_W-1:0];

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            busy     <= 1'b0;
            ready_q  <= 1'b0;
            cur_addr <= '0;
            remain   <= '0;
        end
        else
        begin
            if (req_xfer)
            begin
                busy     <= 1'b1;
                ready_q  <= 1'b0;
                cur_addr <= rd_req.addr;
                remain   <= {1'b0, rd_req.len} + 1'b1;
            end
            else
            begin
                // ready rises one cycle after the splitter goes idle
                if (!busy)
                begin
                    ready_q <= 1'b1;
                end
                if (burst_xfer)
                begin
                    cur_addr <= cur_addr + burst_lim[host_mem_pkg::ADDR_W-1:0];
                    remain   <= remain - burst_lim[LEN_W:0];
                    // the final burst of the request has gone out
                    if (32'(remain) == burst_lim)
                    begin
                        busy <= 1'b0;
                    end
                end
            end
        end
    end

endmodule

/* hw/rd_rob.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// read reorder buffer that stores host lines by slot
// and releases them in request order
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module rd_rob
  #(
    parameter int ROB_DEPTH = 16
    )
   (
    input  logic                                clk,
    input  logic                                arst_n,
    input  logic                                alloc_valid,
    input  logic [$clog2(ROB_DEPTH+1)-1:0]      alloc_lines,
    output logic [$clog2(ROB_DEPTH+1)-1:0]      free_slots,
    output logic [host_mem_pkg::TAG_W-1:0]      next_tag,
    input  host_mem_pkg::host_rsp_t             host_rsp,
    input  logic                                host_rsp_valid,
    output logic                                line_valid,
    output logic [host_mem_pkg::DATA_W-1:0]     line_data,
    input  logic                                line_ready
    );

    localparam int CNT_W = $clog2(ROB_DEPTH + 1);
    localparam int IDX_W = $clog2(ROB_DEPTH);

    logic [host_mem_pkg::DATA_W-1:0] mem [ROB_DEPTH];
    // one bit per slot that says the host has returned its line
    logic [ROB_DEPTH-1:0]            filled;
    logic [IDX_W-1:0]                head;
    logic [IDX_W-1:0]                tail;
    logic [IDX_W-1:0]                head_next;
    logic [IDX_W-1:0]                tail_next;
    logic [CNT_W:0]                  tail_sum;
    logic [CNT_W-1:0]                free_next;
    logic [IDX_W-1:0]                wr_idx;
    logic                            line_xfer;

    assign wr_idx    = host_rsp.tag[IDX_W-1:0];
    assign next_tag  = host_mem_pkg::TAG_W'(tail);

    // the head slot is offered as soon as its line has landed
    assign line_valid = filled[head];
    assign line_data  = mem[head];
    assign line_xfer  = line_valid && line_ready;

    always_comb
    begin
        // the tail moves by a whole burst and wraps at the buffer depth
        tail_sum = (CNT_W+1)'(tail) + (CNT_W+1)'(alloc_lines);
        if (tail_sum >= (CNT_W+1)'(ROB_DEPTH))
        begin
            tail_sum = tail_sum - (CNT_W+1)'(ROB_DEPTH);
        end
        tail_next = tail_sum[IDX_W-1:0];
    end

    always_comb
    begin
        if (head == IDX_W'(ROB_DEPTH - 1))
        begin
            head_next = '0;
        end
        else
        begin
            head_next = head + 1'b1;
        end
    end

    always_comb
    begin
        // allocation takes slots and a released line gives one back
        free_next = free_slots;
        if (alloc_valid)
        begin
            free_next = free_next - alloc_lines;
        end
        if (line_xfer)
        begin
            free_next = free_next + 1'b1;
        end
    end

    // host lines are written straight into the slot named by their tag
    always_ff @(posedge clk)
    begin
        if (host_rsp_valid)
        begin
            mem[wr_idx] <= host_rsp.data;
        end
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            filled     <= '0;
            head       <= '0;
            tail       <= '0;
            free_slots <= CNT_W'(ROB_DEPTH);
        end
        else
        begin
            // a returning line never targets the head slot being released
            // because that slot is already filled
            if (host_rsp_valid)
            begin
                filled[wr_idx] <= 1'b1;
            end
            if (line_xfer)
            begin
                filled[head] <= 1'b0;
                head         <= head_next;
            end
            if (alloc_valid)
            begin
                tail <= tail_next;
            end
            free_slots <= free_next;
        end
    end

endmodule

/* hw/rsp_pack.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// response packer restores id and last on ordered lines
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module rsp_pack
  #(
    parameter int ROB_DEPTH = 16
    )
   (
    input  logic                                clk,
    input  logic                                arst_n,
    input  host_mem_pkg::rsp_hdr_t              hdr,
    input  logic                                hdr_valid,
    input  logic                                line_valid,
    input  logic [host_mem_pkg::DATA_W-1:0]     line_data,
    output logic                                line_ready,
    output host_mem_pkg::rd_rsp_t               rd_rsp,
    output logic                                rd_rsp_valid,
    input  logic                                rd_rsp_ready
    );

    // up to ROB_DEPTH issued requests each hold a slot and one more may be splitting
    // one spare entry keeps a full FIFO apart from an empty one
    localparam int HDR_DEPTH = ROB_DEPTH + 2;
    localparam int PTR_W     = $clog2(HDR_DEPTH);

    host_mem_pkg::rsp_hdr_t             hdr_fifo [HDR_DEPTH];
    host_mem_pkg::rsp_hdr_t             head_hdr;
    logic [PTR_W-1:0]                   wr_ptr;
    logic [PTR_W-1:0]                   rd_ptr;
    logic [host_mem_pkg::LEN_W-1:0]     beat_cnt;
    logic                               hdr_avail;
    logic                               rsp_xfer;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
        if (p == PTR_W'(HDR_DEPTH - 1))
        begin
            return '0;
        end
        return p + 1'b1;
    endfunction

    // the FIFO never fills, so equal pointers mean it is empty
    assign hdr_avail = (wr_ptr != rd_ptr);
    assign head_hdr  = hdr_fifo[rd_ptr];

    // lines pass straight through and pick up the head header fields
    assign rd_rsp.id    = head_hdr.id;
    assign rd_rsp.data  = line_data;
    assign rd_rsp.last  = (beat_cnt == head_hdr.len);
    assign rd_rsp_valid = line_valid && hdr_avail;
    assign line_ready   = rd_rsp_ready && hdr_avail;
    assign rsp_xfer     = rd_rsp_valid && rd_rsp_ready;

    always_ff @(posedge clk)
    begin
        if (hdr_valid)
        begin
            hdr_fifo[wr_ptr] <= hdr;
        end
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            beat_cnt <= '0;
        end
        else
        begin
            if (hdr_valid)
            begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (rsp_xfer)
            begin
                // the last line retires its header and restarts the count
                if (rd_rsp.last)
                begin
                    rd_ptr   <= ptr_inc(rd_ptr);
                    beat_cnt <= '0;
                end
                else
                begin
                    beat_cnt <= beat_cnt + 1'b1;
                end
            end
        end
    end

endmodule

/* hw/host_mem_map.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// host memory read map with splitter, reorder buffer and packer
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module host_mem_map
  #(
    // reorder slots, also the number of read credits
    parameter int ROB_DEPTH       = 16,
    parameter int MAX_BURST_LINES = 4,
    // must be a power of two
    parameter int PAGE_LINES      = 8
    )
   (
    input  logic                        clk,
    input  logic                        arst_n,
    input  host_mem_pkg::rd_req_t       rd_req,
    input  logic                        rd_req_valid,
    output logic                        rd_req_ready,
    output host_mem_pkg::host_req_t     host_req,
    output logic                        host_req_valid,
    input  logic                        host_req_ready,
    input  host_mem_pkg::host_rsp_t     host_rsp,
    input  logic                        host_rsp_valid,
    output host_mem_pkg::rd_rsp_t       rd_rsp,
    output logic                        rd_rsp_valid,
    input  logic                        rd_rsp_ready
    );

    localparam int CNT_W = $clog2(ROB_DEPTH + 1);

    host_mem_pkg::rsp_hdr_t             hdr;
    logic                               hdr_valid;
    logic                               alloc_valid;
    logic [CNT_W-1:0]                   alloc_lines;
    logic [CNT_W-1:0]                   free_slots;
    logic [host_mem_pkg::TAG_W-1:0]     next_tag;
    logic                               line_valid;
    logic [host_mem_pkg::DATA_W-1:0]    line_data;
    logic                               line_ready;

    // cuts requests into host bursts and spends reorder credits
    burst_splitter
      #(
        .ROB_DEPTH(ROB_DEPTH),
        .MAX_BURST_LINES(MAX_BURST_LINES),
        .PAGE_LINES(PAGE_LINES)
        )
      u_splitter
       (
        .clk, .arst_n,
        .rd_req, .rd_req_valid, .rd_req_ready,
        .host_req, .host_req_valid, .host_req_ready,
        .hdr, .hdr_valid,
        .alloc_valid, .alloc_lines,
        .free_slots, .next_tag
        );

    // host lines come back in any order and leave here sorted
    rd_rob
      #(
        .ROB_DEPTH(ROB_DEPTH)
        )
      u_rob
       (
        .clk, .arst_n,
        .alloc_valid, .alloc_lines,
        .free_slots, .next_tag,
        .host_rsp, .host_rsp_valid,
        .line_valid, .line_data, .line_ready
        );

    rsp_pack
      #(
        .ROB_DEPTH(ROB_DEPTH)
        )
      u_pack
       (
        .clk, .arst_n,
        .hdr, .hdr_valid,
        .line_valid, .line_data, .line_ready,
        .rd_rsp, .rd_rsp_valid, .rd_rsp_ready
        );

endmodule

/* tb/clk_gen.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench clock and reset source
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module clk_gen
  #(
    parameter int PERIOD_NS    = 20,
    parameter int RESET_CYCLES = 2
    )
   (
    output logic clk,
    output logic arst_n
    );

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #(PERIOD_NS / 2) clk = ~clk;
        end
    end

    // reset is released a little after a rising edge, never on one
    initial
    begin
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #2 arst_n = 1'b1;
    end

endmodule

/* tb/host_mem_map_assert.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// protocol and burst shape assertions for the read map
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module host_mem_map_assert
  #(
    parameter int MAX_BURST_LINES = 4,
    parameter int PAGE_LINES      = 8
    )
   (
    input  logic                        clk,
    input  logic                        arst_n,
    input  host_mem_pkg::host_req_t     host_req,
    input  logic                        host_req_valid,
    input  logic                        host_req_ready,
    input  host_mem_pkg::rd_rsp_t       rd_rsp,
    input  logic                        rd_rsp_valid,
    input  logic                        rd_rsp_ready
    );

    localparam int PG_W = $clog2(PAGE_LINES);

    // the testbench reads this count at the end of the run
    int fail_count = 0;

    // the last line of a burst stays in the page of its first line
    page_safe: assert property (@(posedge clk) disable iff (!arst_n)
        host_req_valid |-> int'(host_req.addr[PG_W-1:0]) + int'(host_req.len) < PAGE_LINES)
    else
    begin
        $error("host burst at %h crosses a page boundary", host_req.addr);
        fail_count++;
    end

    // len holds lines minus one
    burst_len: assert property (@(posedge clk) disable iff (!arst_n)
        host_req_valid |-> int'(host_req.len) < MAX_BURST_LINES)
    else
    begin
        $error("host burst of %0d lines is too long", int'(host_req.len) + 1);
        fail_count++;
    end

    host_hold: assert property (@(posedge clk) disable iff (!arst_n)
        host_req_valid && !host_req_ready |=> host_req_valid && $stable(host_req))
    else
    begin
        $error("host request changed while stalled");
        fail_count++;
    end

    rsp_hold: assert property (@(posedge clk) disable iff (!arst_n)
        rd_rsp_valid && !rd_rsp_ready |=> rd_rsp_valid && $stable(rd_rsp))
    else
    begin
        $error("client response changed while stalled");
        fail_count++;
    end

    reset_quiet: assert property (@(posedge clk)
        !arst_n |-> !host_req_valid && !rd_rsp_valid)
    else
    begin
        $error("valid raised during reset");
        fail_count++;
    end

endmodule

bind host_mem_map host_mem_map_assert
  #(
    .MAX_BURST_LINES(MAX_BURST_LINES),
    .PAGE_LINES(PAGE_LINES)
    )
  u_assert
   (
    .clk(clk),
    .arst_n(arst_n),
    .host_req(host_req),
    .host_req_valid(host_req_valid),
    .host_req_ready(host_req_ready),
    .rd_rsp(rd_rsp),
    .rd_rsp_valid(rd_rsp_valid),
    .rd_rsp_ready(rd_rsp_ready)
    );

/* tb/host_mem_map_tb.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for the read map with an out of order host memory
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module host_mem_map_tb;

    localparam int ROB_DEPTH = 16;

    // each stimulus line also gives the cycles rd_rsp_ready stays low after it is taken
    typedef struct packed {
        logic [3:0]  id;
        logic [15:0] addr;
        logic [4:0]  lines;
        logic [7:0]  bursts;
        logic [7:0]  hold;
    } stim_t;

    // one line waiting in the host memory model
    typedef struct packed {
        logic [3:0]  tag;
        logic [15:0] addr;
    } line_t;

    logic                       clk;
    logic                       arst_n;
    host_mem_pkg::rd_req_t      rd_req;
    logic                       rd_req_valid;
    logic                       rd_req_ready;
    host_mem_pkg::host_req_t    host_req;
    logic                       host_req_valid;
    logic                       host_req_ready;
    host_mem_pkg::host_rsp_t    host_rsp;
    logic                       host_rsp_valid;
    host_mem_pkg::rd_rsp_t      rd_rsp;
    logic                       rd_rsp_valid;
    logic                       rd_rsp_ready;

    stim_t       stim[$];
    line_t       mem_q[$];
    logic [15:0] lfsr = 16'd19554;
    logic [15:0] split_addr;
    bit          loaded = 1'b0;
    bit          req_taken = 1'b0;
    int          errors = 0;
    int          next_req = 0;
    int          accepted = 0;
    int          hold_cnt = 0;
    int          split_idx = 0;
    int          split_left = 0;
    int          split_bursts = 0;
    int          issued_lines = 0;
    int          rsp_idx = 0;
    int          rsp_beat = 0;
    int          lines_seen = 0;
    int          outstanding = 0;
    int          stall_cycles = 0;

    clk_gen u_clk_gen (.clk(clk), .arst_n(arst_n));

    host_mem_map
      #(
        .ROB_DEPTH(ROB_DEPTH),
        .MAX_BURST_LINES(4),
        .PAGE_LINES(8)
        )
      u_host_mem_map
       (
        .clk, .arst_n,
        .rd_req, .rd_req_valid, .rd_req_ready,
        .host_req, .host_req_valid, .host_req_ready,
        .host_rsp, .host_rsp_valid,
        .rd_rsp, .rd_rsp_valid, .rd_rsp_ready
        );

    // 16 bit Fibonacci register with taps 16, 14, 13 and 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic draw_bits(input int n, output int bits);
        bits = 0;
        for (int i = 0; i < n; i++)
        begin
            lfsr = lfsr_next(lfsr);
            bits = (bits << 1) | int'(lfsr[0]);
        end
    endtask

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (expected !== actual)
        begin
            $display("ERROR at %0t ns: %s expected %0h, got %0h", $time, name, expected, actual);
            errors++;
        end
    endtask

    // sampled right at the clock edge, before the DUT registers move
    task automatic observe_cycle();
        line_t ln;
        stim_t s;
        int    blen;
        // the splitter holds lines but offers nothing, so credits are short
        if (split_idx < accepted && !host_req_valid)
        begin
            stall_cycles++;
        end
        if (rd_req_valid && rd_req_ready)
        begin
            hold_cnt = int'(stim[accepted].hold);
            accepted++;
            req_taken = 1'b1;
        end
        if (host_req_valid && host_req_ready)
        begin
            blen = int'(host_req.len) + 1;
            // slots are handed out in issue order, so the first slot follows the line count
            check_value("host_req.tag", 64'(issued_lines % ROB_DEPTH), 64'(host_req.tag));
            issued_lines = issued_lines + blen;
            if (split_idx >= accepted)
            begin
                $display("ERROR at %0t ns: host burst with no client request open", $time);
                errors++;
            end
            else
            begin
                if (split_left == 0)
                begin
                    split_addr   = stim[split_idx].addr;
                    split_left   = int'(stim[split_idx].lines);
                    split_bursts = 0;
                end
                check_value("host_req.addr", 64'(split_addr), 64'(host_req.addr));
                if (blen > split_left)
                begin
                    $display("ERROR at %0t ns: host burst runs past its request", $time);
                    errors++;
                end
                split_addr   = split_addr + 16'(blen);
                split_left   = split_left - blen;
                split_bursts = split_bursts + 1;
                if (split_left <= 0)
                begin
                    check_value("host burst count", 64'(stim[split_idx].bursts),
                                64'(split_bursts));
                    split_left = 0;
                    split_idx++;
                end
            end
            // the host memory keeps one entry per line of the burst
            for (int i = 0; i < blen; i++)
            begin
                ln.tag  = 4'((int'(host_req.tag) + i) % ROB_DEPTH);
                ln.addr = host_req.addr + 16'(i);
                mem_q.push_back(ln);
            end
            outstanding = outstanding + blen;
        end
        if (rd_rsp_valid && rd_rsp_ready)
        begin
            if (rsp_idx >= stim.size())
            begin
                $display("ERROR at %0t ns: response line after the last request", $time);
                errors++;
            end
            else
            begin
                s = stim[rsp_idx];
                check_value("rd_rsp.id", 64'(s.id), 64'(rd_rsp.id));
                check_value("rd_rsp.data", 64'({16'hA5A5, s.addr + 16'(rsp_beat)}),
                            64'(rd_rsp.data));
                check_value("rd_rsp.last", 64'(rsp_beat == int'(s.lines) - 1),
                            64'(rd_rsp.last));
                if (rsp_beat == int'(s.lines) - 1)
                begin
                    rsp_beat = 0;
                    rsp_idx++;
                end
                else
                begin
                    rsp_beat++;
                end
            end
            lines_seen++;
            outstanding--;
        end
        if (outstanding > ROB_DEPTH)
        begin
            $display("ERROR at %0t ns: more lines in flight than reorder slots", $time);
            errors++;
        end
    endtask

    // every random draw lives here so the LFSR is stepped in one process
    task automatic drive_cycle();
        int    bits;
        int    pick;
        line_t ln;
        if (req_taken)
        begin
            rd_req_valid = 1'b0;
            req_taken    = 1'b0;
        end
        if (!rd_req_valid && next_req < stim.size())
        begin
            rd_req.id    = stim[next_req].id;
            rd_req.addr  = stim[next_req].addr;
            rd_req.len   = 4'(stim[next_req].lines - 5'd1);
            rd_req_valid = 1'b1;
            next_req++;
        end
        draw_bits(2, bits);
        host_req_ready = (bits != 0);
        host_rsp_valid = 1'b0;
        draw_bits(2, bits);
        if (mem_q.size() > 0 && bits != 0)
        begin
            draw_bits(4, pick);
            pick           = pick % mem_q.size();
            ln             = mem_q[pick];
            mem_q.delete(pick);
            host_rsp.tag   = ln.tag;
            host_rsp.data  = {16'hA5A5, ln.addr};
            host_rsp_valid = 1'b1;
        end
        if (hold_cnt > 0)
        begin
            rd_rsp_ready = 1'b0;
            hold_cnt--;
        end
        else
        begin
            draw_bits(2, bits);
            rd_rsp_ready = (bits != 0);
        end
    endtask

    always @(posedge clk)
    begin
        if (arst_n)
        begin
            observe_cycle();
            #2;
            drive_cycle();
        end
    end

    initial
    begin
        int    fd;
        int    id;
        int    addr;
        int    lines;
        int    bursts;
        int    hold;
        int    total;
        string text;
        stim_t s;
        rd_req         = '0;
        rd_req_valid   = 1'b0;
        host_req_ready = 1'b0;
        host_rsp       = '0;
        host_rsp_valid = 1'b0;
        rd_rsp_ready   = 1'b0;
        total          = 0;
        fd = $fopen("tb/host_mem_stimulus.txt", "r");
        if (fd == 0)
        begin
            $display("ERROR: the stimulus file tb/host_mem_stimulus.txt cannot be opened");
            $display("Test failed");
            $finish;
        end
        else
        begin
            while (!$feof(fd))
            begin
                if ($fgets(text, fd) > 0)
                begin
                    // lines that start with a hash are column notes
                    if (text[0] != "#" &&
                        $sscanf(text, "%h %h %d %d %d", id, addr, lines, bursts, hold) == 5)
                    begin
                        s.id     = 4'(id);
                        s.addr   = 16'(addr);
                        s.lines  = 5'(lines);
                        s.bursts = 8'(bursts);
                        s.hold   = 8'(hold);
                        stim.push_back(s);
                        total = total + lines;
                    end
                end
            end
            $fclose(fd);
            loaded = 1'b1;
            wait (rsp_idx == stim.size());
            // a few idle cycles catch any extra response line
            repeat (10) @(posedge clk);
            check_value("response lines", 64'(total), 64'(lines_seen));
            check_value("requests split", 64'(stim.size()), 64'(split_idx));
            check_value("host lines left", 64'd0, 64'(mem_q.size()));
            if (stall_cycles == 0)
            begin
                $display("ERROR: host bursts never waited for reorder credits");
                errors++;
            end
            $display("errors: %0d failed checks, %0d failed assertions",
                     errors, u_host_mem_map.u_assert.fail_count);
            if (errors == 0 && u_host_mem_map.u_assert.fail_count == 0)
            begin
                $display("Test completed successfully");
            end
            else
            begin
                $display("Test failed");
            end
            $finish;
        end
    end

    // the limit grows with the number of requests read
    initial
    begin
        wait (loaded);
        repeat (200 * stim.size() + 100) @(posedge clk);
        $display("ERROR: timeout, %0d of %0d requests answered", rsp_idx, stim.size());
        $display("Test failed");
        $finish;
    end

endmodule

/* tb/host_mem_stimulus.txt */
# columns: id (hex) address (hex) lines bursts hold
# hold counts the cycles rd_rsp_ready is kept low after the request is taken
1 0000 1 1 0
2 0004 4 1 0
3 0006 4 2 0
4 0011 8 3 0
5 0020 16 4 0
6 0037 3 2 0
7 0103 5 2 0
8 00fd 7 2 0
9 0200 16 4 80
a 02fe 16 5 0
b 0401 2 1 0
c 0417 12 4 0
d fffc 4 1 0
e 0805 9 3 0
f 0a00 1 1 0
0 0c02 16 5 0

/* src.f */
hw/host_mem_pkg.sv
hw/burst_splitter.sv
hw/rd_rob.sv
hw/rsp_pack.sv
hw/host_mem_map.sv
tb/clk_gen.sv
tb/host_mem_map_assert.sv
tb/host_mem_map_tb.sv

/* Makefile */
# Verilator build and run for the host memory read map

VERILATOR ?= verilator
TOP       ?= host_mem_map_tb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
SIM_ARGS  ?= +verilator+error+limit+100
PASS_MSG  := Test completed successfully

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: $(SIM_BIN)
	./$(SIM_BIN) $(SIM_ARGS) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
